//--- upMemPkg.sv
//--------------------
// Shared types and memory map for the uP memory side
// Bus request struct, address views, processor state and map constants
// Every design file imports this package inside its module body
//--------------------
package upMemPkg;

	// One master's request on the memory bus
	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] data;
		logic        wr;   // 1 = write, 0 = read
		logic        en;   // Request valid
	} memBus_t;

	// Same address word seen as raw index or as map fields
	typedef union packed {
		logic [15:0] raw;   // RAM index view
		struct packed {
			logic [1:0]  region;  // Top bits select mapped space
			logic [11:0] unused;
			logic [1:0]  regSel;  // Register offset in map
		} map;
	} memAddr_u;

	// Processor state
	typedef enum logic [1:0] {
		ST_BOOT  = 2'd0,
		ST_RUN   = 2'd1,
		ST_PAUSE = 2'd2
	} upState_e;

	//--------------------
	// Memory map
	localparam logic [1:0] MAP_REGION = 2'b11;  // Region of the mapped regs
	localparam int         RAM_WORDS  = 256;    // Word RAM depth
	localparam int         RAM_AW     = 8;      // RAM index width
	localparam int         BOOT_LEN   = 8;      // Words in boot image

	// Mapped register offsets, offset 3 reads zero
	localparam logic [1:0] REG_GPIO_OUT = 2'd0;
	localparam logic [1:0] REG_SCRATCH  = 2'd1;
	localparam logic [1:0] REG_GPIO_IN  = 2'd2;

endpackage

//--- MemController.sv
//--------------------
// Central controller of the uP memory bus
// Picks bootloader, core or JTAG by processor state, registers the
// request on the falling edge so memory acts in the second half cycle
// Sole driver of the tristate data bus
//--------------------
`timescale 1ns/1ns

module MemController (
	input  logic              i_clk,
	input  logic              i_rstN,

	// Bus masters
	input  upMemPkg::memBus_t i_jtagReq,
	input  upMemPkg::memBus_t i_bootReq,
	input  upMemPkg::memBus_t i_coreReq,

	// Processor state
	input  logic              i_smIsPaused,
	input  logic              i_smIsBooted,

	// Read data back from both memories
	input  logic [15:0]       i_ramReadData,
	input  logic [15:0]       i_mapReadData,

	// Registered bus toward memories
	output upMemPkg::memBus_t o_runBus,
	output logic              o_runEn,
	output logic              o_mapWrEn,
	inout  wire  [15:0]       io_memData
);
	import upMemPkg::*;

	memBus_t     selReq;     // Master chosen this cycle
	memBus_t     runQ;       // Falling edge copy
	memAddr_u    runAddr;
	logic        isMapAddr;
	logic        isWrite;
	logic        isMapRead;
	logic        isRamRead;
	logic        driveEn;
	logic [15:0] busOut;

	//--------------------
	// Master select
	always_comb begin
		if (!i_smIsBooted) begin
			selReq    = i_bootReq;
			selReq.wr = 1'b1;       // Bootloader only writes
		end else if (i_smIsPaused) begin
			selReq = i_jtagReq;     // Debugger owns the bus
		end else begin
			selReq    = i_coreReq;
			selReq.en = 1'b1;       // Core always enabled while running
		end
	end

	// Register on falling edge so wr/en settle before memory sees them
	always_ff @(negedge i_clk) begin
		if (!i_rstN) begin
			runQ <= '0;
		end else begin
			runQ <= selReq;
		end
	end

	//--------------------
	// Decode from registered request
	assign runAddr   = runQ.addr;
	assign isMapAddr = (runAddr.map.region == MAP_REGION);
	assign isWrite   = runQ.en & runQ.wr;
	assign isMapRead = runQ.en & ~runQ.wr & isMapAddr;
	assign isRamRead = runQ.en & ~runQ.wr & ~isMapAddr;

	// Data bus source
	always_comb begin
		if (isWrite) begin
			busOut = runQ.data;        // Master write data
		end else if (isMapRead) begin
			busOut = i_mapReadData;
		end else begin
			busOut = i_ramReadData;
		end
	end

	assign driveEn    = isWrite | isMapRead | isRamRead;
	assign io_memData = driveEn ? busOut : 16'bz;  // Float when idle

	//--------------------
	// Outputs to memories
	assign o_runBus  = runQ;
	assign o_runEn   = runQ.en & ~isMapAddr;
	assign o_mapWrEn = isWrite & isMapAddr & i_smIsBooted;  // Map locked during boot

endmodule

//--- BootLoader.sv
//--------------------
// Bootloader front end
// Each valid boot word becomes a bus write, done pulses on the last word
//--------------------
`timescale 1ns/1ns

module BootLoader (
	input  logic              i_clk,
	input  logic              i_rstN,
	input  logic              i_bootValid,
	input  logic [15:0]       i_bootAddr,
	input  logic [15:0]       i_bootData,
	input  logic              i_isBooted,
	output upMemPkg::memBus_t o_bootReq,
	output logic              o_bootDone
);
	import upMemPkg::*;

	logic [$clog2(BOOT_LEN)-1:0] wordCnt;  // Words taken so far
	logic                        accept;

	assign accept = i_bootValid & ~i_isBooted;  // Stream ignored once booted

	// Write request in same cycle as valid
	assign o_bootReq.addr = i_bootAddr;
	assign o_bootReq.data = i_bootData;
	assign o_bootReq.wr   = 1'b1;
	assign o_bootReq.en   = accept;

	// Single cycle pulse on last word
	assign o_bootDone = accept & (wordCnt == BOOT_LEN - 1);

	always_ff @(posedge i_clk) begin
		if (!i_rstN) begin
			wordCnt <= '0;
		end else if (accept) begin
			wordCnt <= wordCnt + 1'b1;
		end
	end

endmodule

//--- UpStateMachine.sv
//--------------------
// Processor state FSM
// Boot until bootloader finishes, then run, JTAG pulses pause and resume
//--------------------
`timescale 1ns/1ns

module UpStateMachine (
	input  logic i_clk,
	input  logic i_rstN,
	input  logic i_bootDone,
	input  logic i_jtagHalt,
	input  logic i_jtagResume,
	output logic o_smIsBooted,
	output logic o_smIsPaused
);
	import upMemPkg::*;

	upState_e state;
	upState_e stateNext;

	always_comb begin
		stateNext = state;
		case (state)
			ST_BOOT:  if (i_bootDone)   stateNext = ST_RUN;
			ST_RUN:   if (i_jtagHalt)   stateNext = ST_PAUSE;
			ST_PAUSE: if (i_jtagResume) stateNext = ST_RUN;
			default:  stateNext = ST_BOOT;  // Unused code recovers to boot
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (!i_rstN) begin
			state <= ST_BOOT;
		end else begin
			state <= stateNext;
		end
	end

	assign o_smIsBooted = (state == ST_RUN) | (state == ST_PAUSE);
	assign o_smIsPaused = (state == ST_PAUSE);

endmodule

//--- MainMemory.sv
//--------------------
// Word RAM behind the non-mapped address space
// Writes at rising edge, reads combinationally from registered address
//--------------------
`timescale 1ns/1ns

module MainMemory (
	input  logic              i_clk,
	input  upMemPkg::memBus_t i_runBus,
	input  logic              i_runEn,
	output logic [15:0]       o_ramReadData
);
	import upMemPkg::*;

	logic [15:0]       mem [RAM_WORDS];
	memAddr_u          addr;
	logic [RAM_AW-1:0] idx;

	assign addr = i_runBus.addr;
	assign idx  = addr.raw[RAM_AW-1:0];  // Upper bits alias

	// Write port
	always_ff @(posedge i_clk) begin
		if (i_runEn && i_runBus.wr) begin
			mem[idx] <= i_runBus.data;
		end
	end

	assign o_ramReadData = mem[idx];  // Async read

endmodule

//--- MappedRegs.sv
//--------------------
// Mapped registers at top of address space
// GPIO out and scratch are writable, GPIO in is read only
//--------------------
`timescale 1ns/1ns

module MappedRegs (
	input  logic              i_clk,
	input  logic              i_rstN,
	input  upMemPkg::memBus_t i_runBus,
	input  logic              i_mapWrEn,
	input  logic [15:0]       i_gpioIn,
	output logic [15:0]       o_mapReadData,
	output logic [15:0]       o_gpio
);
	import upMemPkg::*;

	memAddr_u    addr;
	logic [15:0] gpioOut;
	logic [15:0] scratch;

	assign addr = i_runBus.addr;

	// Register writes
	always_ff @(posedge i_clk) begin
		if (!i_rstN) begin
			gpioOut <= '0;
			scratch <= '0;
		end else if (i_mapWrEn) begin
			if (addr.map.regSel == REG_GPIO_OUT) gpioOut <= i_runBus.data;
			if (addr.map.regSel == REG_SCRATCH)  scratch <= i_runBus.data;
		end
	end

	// Read mux
	always_comb begin
		case (addr.map.regSel)
			REG_GPIO_OUT: o_mapReadData = gpioOut;
			REG_SCRATCH:  o_mapReadData = scratch;
			REG_GPIO_IN:  o_mapReadData = i_gpioIn;
			default:      o_mapReadData = '0;  // Offset 3 reserved
		endcase
	end

	assign o_gpio = gpioOut;

endmodule

//--- MicroMemTop.sv
//--------------------
// Top of the uP memory side
// Packs core, JTAG and boot pins into bus requests and wires the
// state machine, controller, RAM and mapped registers together
//--------------------
`timescale 1ns/1ns

module MicroMemTop (
	input  logic        i_clk,
	input  logic        i_rstN,

	// JTAG pins
	input  logic [15:0] i_jtagAddr,
	input  logic [15:0] i_jtagData,
	input  logic        i_jtagWr,
	input  logic        i_jtagEn,
	input  logic        i_jtagHalt,
	input  logic        i_jtagResume,

	// Core pins
	input  logic [15:0] i_coreAddr,
	input  logic [15:0] i_coreData,
	input  logic        i_coreWr,

	// Boot stream
	input  logic        i_bootValid,
	input  logic [15:0] i_bootAddr,
	input  logic [15:0] i_bootData,

	input  logic [15:0] i_gpioIn,
	output logic [15:0] o_busData,
	output logic [15:0] o_gpio,
	output logic        o_isBooted,
	output logic        o_isPaused
);
	import upMemPkg::*;

	memBus_t     jtagReq;
	memBus_t     bootReq;
	memBus_t     coreReq;
	memBus_t     runBus;
	logic        bootDone;
	logic        smIsBooted;
	logic        smIsPaused;
	logic        runEn;
	logic        mapWrEn;
	logic [15:0] ramReadData;
	logic [15:0] mapReadData;
	wire  [15:0] memData;      // Shared tristate bus

	assign jtagReq = '{addr: i_jtagAddr, data: i_jtagData, wr: i_jtagWr, en: i_jtagEn};
	assign coreReq = '{addr: i_coreAddr, data: i_coreData, wr: i_coreWr, en: 1'b0};  // No core enable pin

	//--------------------
	// Masters and state
	BootLoader BOOT (
		.i_clk(i_clk), .i_rstN(i_rstN),
		.i_bootValid(i_bootValid), .i_bootAddr(i_bootAddr), .i_bootData(i_bootData),
		.i_isBooted(smIsBooted), .o_bootReq(bootReq), .o_bootDone(bootDone)
	);

	UpStateMachine SM (
		.i_clk(i_clk), .i_rstN(i_rstN), .i_bootDone(bootDone),
		.i_jtagHalt(i_jtagHalt), .i_jtagResume(i_jtagResume),
		.o_smIsBooted(smIsBooted), .o_smIsPaused(smIsPaused)
	);

	//--------------------
	// Bus control and memories
	MemController CTRL (
		.i_clk(i_clk), .i_rstN(i_rstN),
		.i_jtagReq(jtagReq), .i_bootReq(bootReq), .i_coreReq(coreReq),
		.i_smIsPaused(smIsPaused), .i_smIsBooted(smIsBooted),
		.i_ramReadData(ramReadData), .i_mapReadData(mapReadData),
		.o_runBus(runBus), .o_runEn(runEn), .o_mapWrEn(mapWrEn), .io_memData(memData)
	);

	MainMemory RAM (
		.i_clk(i_clk), .i_runBus(runBus), .i_runEn(runEn), .o_ramReadData(ramReadData)
	);

	MappedRegs MAP (
		.i_clk(i_clk), .i_rstN(i_rstN), .i_runBus(runBus), .i_mapWrEn(mapWrEn),
		.i_gpioIn(i_gpioIn), .o_mapReadData(mapReadData), .o_gpio(o_gpio)
	);

	assign o_busData  = memData;  // Z passes through when undriven
	assign o_isBooted = smIsBooted;
	assign o_isPaused = smIsPaused;

endmodule

//--- MicroMemChecker.sv
//--------------------
// Output checker for the uP memory side testbench
// Samples the DUT outputs 1 ns before each rising edge and compares
// the masked ones with the expected values of the current row
//--------------------
`timescale 1ns/1ns

module MicroMemChecker (
	input  logic        i_clk,
	input  logic        i_chkEn,
	input  logic [3:0]  i_mask,      // Bus, gpio, booted, paused
	input  logic [15:0] i_expBus,
	input  logic [15:0] i_expGpio,
	input  logic        i_expBooted,
	input  logic        i_expPaused,
	input  logic [15:0] i_busData,
	input  logic [15:0] i_gpio,
	input  logic        i_isBooted,
	input  logic        i_isPaused,
	output logic [31:0] o_errCount
);
	localparam int SAMPLE_DELAY = 3;  // Falling edge to 1 ns before rise

	int checkCount = 0;
	int errCount   = 0;

	// Four-state compare so a floating bus counts
	task automatic compareValue(input string name, input logic [15:0] expVal,
			input logic [15:0] actVal);
		checkCount++;
		if (actVal !== expVal) begin
			errCount++;
			$display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
		end
	endtask

	always @(negedge i_clk) begin
		#SAMPLE_DELAY;
		if (i_chkEn) begin
			if (i_mask[0]) compareValue("o_busData", i_expBus, i_busData);
			if (i_mask[1]) compareValue("o_gpio", i_expGpio, i_gpio);
			if (i_mask[2]) compareValue("o_isBooted", i_expBooted, i_isBooted);
			if (i_mask[3]) compareValue("o_isPaused", i_expPaused, i_isPaused);
		end
	end

	assign o_errCount = errCount;

	task automatic printSummary();
		$display("Checks: %0d, errors: %0d", checkCount, errCount);
	endtask

endmodule

//--- MicroMemTb.sv
//--------------------
// Testbench for the uP memory side
// A table holds one row per clock, applied 1 ns after the rising edge
// MicroMemChecker samples the outputs and does the comparing
//--------------------
`timescale 1ns/1ns

module MicroMemTb;
	import upMemPkg::*;

	typedef enum logic [3:0] {
		OP_IDLE, OP_BOOT, OP_CORE_WR, OP_CORE_RD, OP_JTAG_WR,
		OP_JTAG_RD, OP_HALT, OP_RESUME, OP_WAIT_BOOT
	} tbOp_e;

	// One clock of stimulus and what the outputs show in that clock
	typedef struct packed {
		tbOp_e       op;
		logic [15:0] addr;      // Address for the master that owns the row
		logic [15:0] data;
		logic [15:0] expBus;    // z where the bus floats
		logic [15:0] expGpio;
		upState_e    expState;
		logic [3:0]  mask;      // Bit 0 bus, 1 gpio, 2 booted, 3 paused
	} stimRow_t;

	localparam logic [3:0]  CHK_ALL  = 4'b1111;
	localparam logic [15:0] GPIO_IN  = 16'h5a3c;
	localparam int          WAIT_MAX = 40;     // Cycles allowed for boot done

	logic        clk, rstN, chkEn, timedOut, expBooted, expPaused;
	logic        jtagWr, jtagEn, jtagHalt, jtagResume, coreWr, bootValid;
	logic [15:0] jtagAddr, jtagData, coreAddr, coreData, bootAddr, bootData;
	logic [15:0] gpioIn, expBus, expGpio;
	logic [3:0]  chkMask;
	logic [31:0] errCount;
	logic [31:0] lfsr;
	logic [15:0] bootWords [BOOT_LEN];
	logic [15:0] bootAddrs [BOOT_LEN];
	stimRow_t    rows [$];
	wire  [15:0] busData, gpio;
	wire         isBooted, isPaused;

	MicroMemTop UUT (
		.i_clk(clk), .i_rstN(rstN),
		.i_jtagAddr(jtagAddr), .i_jtagData(jtagData), .i_jtagWr(jtagWr), .i_jtagEn(jtagEn),
		.i_jtagHalt(jtagHalt), .i_jtagResume(jtagResume),
		.i_coreAddr(coreAddr), .i_coreData(coreData), .i_coreWr(coreWr),
		.i_bootValid(bootValid), .i_bootAddr(bootAddr), .i_bootData(bootData),
		.i_gpioIn(gpioIn), .o_busData(busData), .o_gpio(gpio),
		.o_isBooted(isBooted), .o_isPaused(isPaused)
	);

	MicroMemChecker CHECK (
		.i_clk(clk), .i_chkEn(chkEn), .i_mask(chkMask),
		.i_expBus(expBus), .i_expGpio(expGpio),
		.i_expBooted(expBooted), .i_expPaused(expPaused),
		.i_busData(busData), .i_gpio(gpio), .i_isBooted(isBooted), .i_isPaused(isPaused),
		.o_errCount(errCount)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;  // 8 ns period

	// Galois LFSR stepping right
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
	endfunction

	task automatic takeRandWord(output logic [15:0] w);
		for (int b = 0; b < 16; b++) begin
			w[b] = lfsr[0];        // One step per bit taken
			lfsr = lfsrNext(lfsr);
		end
	endtask

	function automatic logic [15:0] mapAddr(input logic [1:0] sel);
		return {MAP_REGION, 12'h000, sel};
	endfunction

	task automatic addRow(input tbOp_e op, input logic [15:0] addr, input logic [15:0] data,
			input logic [15:0] expB, input logic [15:0] expG, input upState_e st,
			input logic [3:0] mask);
		rows.push_back({op, addr, data, expB, expG, st, mask});
	endtask

	task automatic driveRow(input stimRow_t r);
		logic isCore;
		logic isJtag;
		logic isBoot;
		isCore     = (r.op == OP_CORE_WR) || (r.op == OP_CORE_RD) || (r.op == OP_HALT);
		isJtag     = (r.op == OP_JTAG_WR) || (r.op == OP_JTAG_RD);
		isBoot     = (r.op == OP_BOOT);
		jtagAddr   = isJtag ? r.addr : ~r.addr;  // Masters not in use see the inverse
		jtagData   = isJtag ? r.data : ~r.data;
		coreAddr   = isCore ? r.addr : ~r.addr;
		coreData   = isCore ? r.data : ~r.data;
		bootAddr   = isBoot ? r.addr : ~r.addr;
		bootData   = isBoot ? r.data : ~r.data;
		jtagWr     = (r.op == OP_JTAG_WR);
		jtagEn     = isJtag;
		jtagHalt   = (r.op == OP_HALT);
		jtagResume = (r.op == OP_RESUME);
		coreWr     = (r.op == OP_CORE_WR);  // Core has no enable pin
		bootValid  = isBoot;
		expBus     = r.expBus;
		expGpio    = r.expGpio;
		expBooted  = (r.expState != ST_BOOT);
		expPaused  = (r.expState == ST_PAUSE);
		chkMask    = r.mask;
		chkEn      = (r.op != OP_WAIT_BOOT);
	endtask

	// Poll o_isBooted once per cycle while inputs stay idle
	task automatic waitBooted(output logic failed);
		int n;
		n = 0;
		while (isBooted !== 1'b1 && n < WAIT_MAX) begin
			@(posedge clk);
			#1;
			n++;
		end
		failed = (isBooted !== 1'b1);
		if (failed) $display("Timed out after %0d cycles waiting for o_isBooted", WAIT_MAX);
	endtask

	//--------------------
	task automatic buildTable();
		for (int i = 0; i < BOOT_LEN; i++) begin
			takeRandWord(bootWords[i]);
			bootAddrs[i] = (i == 3) ? mapAddr(REG_GPIO_OUT) : 16'h0010 + i;  // One map write
		end
		addRow(OP_IDLE, 16'h0, 16'h0, 16'hzzzz, 16'h0, ST_BOOT, CHK_ALL);
		addRow(OP_HALT, 16'h0, 16'h0, 16'hzzzz, 16'h0, ST_BOOT, CHK_ALL);  // No effect in boot
		for (int i = 0; i < BOOT_LEN; i++) begin
			addRow(OP_BOOT, bootAddrs[i], bootWords[i], bootWords[i], 16'h0, ST_BOOT, CHK_ALL);
		end
		addRow(OP_WAIT_BOOT, 16'h0, 16'h0, 16'h0, 16'h0, ST_RUN, 4'b0000);
		for (int i = 0; i < BOOT_LEN; i++) begin
			addRow(OP_CORE_RD, bootAddrs[i], 16'h0, (i == 3) ? 16'h0 : bootWords[i],
				16'h0, ST_RUN, CHK_ALL);       // GPIO out still zero
		end
		addRow(OP_CORE_WR, mapAddr(REG_GPIO_OUT), 16'hbeef, 16'hbeef, 16'h0, ST_RUN, CHK_ALL);
		addRow(OP_CORE_RD, mapAddr(REG_GPIO_IN), 16'h0, GPIO_IN, 16'hbeef, ST_RUN, CHK_ALL);
		addRow(OP_CORE_WR, mapAddr(REG_SCRATCH), 16'h1234, 16'h1234, 16'hbeef, ST_RUN, CHK_ALL);
		addRow(OP_CORE_RD, mapAddr(REG_SCRATCH), 16'h0, 16'h1234, 16'hbeef, ST_RUN, CHK_ALL);
		addRow(OP_CORE_RD, mapAddr(2'd3), 16'h0, 16'h0, 16'hbeef, ST_RUN, CHK_ALL);
		addRow(OP_HALT, bootAddrs[0], 16'h0, bootWords[0], 16'hbeef, ST_RUN, CHK_ALL);
		// Paused with JTAG enable low so the core write goes nowhere and the bus floats
		addRow(OP_CORE_WR, bootAddrs[0], 16'hdead, 16'hzzzz, 16'hbeef, ST_PAUSE, CHK_ALL);
		addRow(OP_JTAG_WR, 16'h0040, 16'h7e57, 16'h7e57, 16'hbeef, ST_PAUSE, CHK_ALL);
		addRow(OP_JTAG_RD, 16'h0040, 16'h0, 16'h7e57, 16'hbeef, ST_PAUSE, CHK_ALL);
		addRow(OP_JTAG_RD, bootAddrs[0], 16'h0, bootWords[0], 16'hbeef, ST_PAUSE, CHK_ALL);
		addRow(OP_RESUME, 16'h0, 16'h0, 16'hzzzz, 16'hbeef, ST_PAUSE, CHK_ALL);
		addRow(OP_CORE_RD, 16'h0040, 16'h0, 16'h7e57, 16'hbeef, ST_RUN, CHK_ALL);
		addRow(OP_CORE_RD, bootAddrs[0], 16'h0, bootWords[0], 16'hbeef, ST_RUN, CHK_ALL);
	endtask

	initial begin
		lfsr     = 32'h12e950a7;
		timedOut = 1'b0;
		rstN     = 1'b0;
		gpioIn   = GPIO_IN;
		driveRow('0);
		chkEn    = 1'b0;   // Nothing compared under reset
		buildTable();
		repeat (16) @(posedge clk);
		#1;
		rstN = 1'b1;
		for (int i = 0; i < rows.size() && !timedOut; i++) begin
			@(posedge clk);
			#1;
			driveRow(rows[i]);
			if (rows[i].op == OP_WAIT_BOOT) waitBooted(timedOut);
		end
		@(posedge clk);
		#1;
		chkEn = 1'b0;
		CHECK.printSummary();
		if (errCount == 0 && !timedOut) $display("All tests passed");
		else $display("Some tests failed");
		$finish;
	end

endmodule

//--- MicroMemTop.f
upMemPkg.sv
MemController.sv
BootLoader.sv
UpStateMachine.sv
MainMemory.sv
MappedRegs.sv
MicroMemTop.sv
MicroMemChecker.sv
MicroMemTb.sv

//--- Bender.yml
package:
  name: micro_mem

sources:
  - upMemPkg.sv
  - MemController.sv
  - BootLoader.sv
  - UpStateMachine.sv
  - MainMemory.sv
  - MappedRegs.sv
  - MicroMemTop.sv
  - target: test
    files:
      - MicroMemChecker.sv
      - MicroMemTb.sv
